//--- vread.f
hw/vread_bus_pkg.sv
hw/vread_cfg_pkg.sv
hw/burst_reader.sv
hw/pattern_addr_gen.sv
hw/dual_port_buffer.sv
hw/vread_unit.sv
hw/vread_top.sv
bench/databus_responder.sv
bench/vread_tb.sv

//--- bench/vread_patterns.txt
// columns: ext_addr length enabled ping_pong start incr shift incr2 per duty iter iter2 delay
//          key stall check (all hex, one run per line)
// ping-pong off, load 32 words, then stream them back in order
00001000 0020 1 0 000 000 000 000 01 01 000 001 00 a5a50000 0 1
00000000 0000 0 0 000 001 008 000 08 08 004 001 02 00000000 0 1
// load 40 words, then a strided read that wraps through incr2
00002000 0028 1 0 000 000 000 000 01 01 000 001 00 5a5a1234 0 1
00000000 0000 0 0 010 002 005 3f8 06 04 003 003 01 00000000 0 1
// ping-pong over three runs, the first read bank was never loaded
00003000 0010 1 1 000 001 004 000 04 04 004 001 00 11110000 0 0
00003100 0010 1 1 000 001 004 000 04 04 004 001 00 22220000 0 1
00003200 0010 1 1 000 001 004 000 04 04 004 001 03 33330000 0 1
// stalled burst into bank 1 with a short stream of bank 0
00004000 0018 1 1 000 001 004 000 04 04 002 001 03 0f0f0f0f 1 1
// stalled data read back with full addresses
00000000 0000 0 0 200 001 008 000 08 08 003 001 00 00000000 0 1

//--- bench/vread_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vread_tb;

   import vread_bus_pkg::*;
   import vread_cfg_pkg::*;

   localparam int RUN_CNT   = 9;
   localparam int FIELD_CNT = 16;

   logic                  clk;
   logic                  rst;
   logic                  run;
   xfer_cfg_t             xfer_cfg;
   agen_cfg_t             agen_cfg;
   logic                  done;
   logic                  dbus_valid;
   dbus_req_t             dbus_req;
   logic                  dbus_ready;
   logic [AXI_DATA_W-1:0] dbus_rdata;
   logic                  dbus_last;
   logic                  out_valid;
   logic [DATA_W-1:0]     out_data;
   logic                  stall;
   logic [31:0]           key;

   logic [31:0]       pat_mem [0:RUN_CNT*FIELD_CNT-1];
   logic [DATA_W-1:0] model_mem [0:(1 << ADDR_W)-1];
   logic [DATA_W-1:0] exp_q [$];
   logic              bank_state;
   logic              in_run;
   logic              first_cycle;
   logic              run_finished;
   logic              check_data;
   dbus_req_t         exp_req;
   int                err_cnt;
   int                check_cnt;
   int                cycle_cnt;
   int                cycle_limit;
   int                run_idx;
   int                out_idx;
   int                beat_cnt;
   int                exp_beats;

   vread_top dut (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run),
      .xfer_cfg_i   (xfer_cfg),
      .agen_cfg_i   (agen_cfg),
      .done_o       (done),
      .dbus_valid_o (dbus_valid),
      .dbus_req_o   (dbus_req),
      .dbus_ready_i (dbus_ready),
      .dbus_rdata_i (dbus_rdata),
      .dbus_last_i  (dbus_last),
      .out_valid_o  (out_valid),
      .out_data_o   (out_data)
   );

   databus_responder u_mem (
      .clk     (clk),
      .rst     (rst),
      .stall_i (stall),
      .key_i   (key),
      .valid_i (dbus_valid),
      .req_i   (dbus_req),
      .ready_o (dbus_ready),
      .rdata_o (dbus_rdata),
      .last_o  (dbus_last)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      check_cnt++;
      if (actual !== expected) begin
         err_cnt++;
         $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic report_failure(input string msg);
      err_cnt++;
      $display("run %0d: %s", run_idx, msg);
   endtask

   // stream predicted from the two-level address formula
   task automatic build_expected();
      logic [ADDR_W-1:0] a;
      exp_q.delete();
      for (int j = 0; j < agen_cfg.iter2; j++) begin
         for (int i = 0; i < agen_cfg.iter; i++) begin
            for (int p = 0; p < agen_cfg.duty && p < agen_cfg.per; p++) begin
               a = agen_cfg.start + j * agen_cfg.incr2 + i * agen_cfg.shift
                   + p * agen_cfg.incr;
               if (xfer_cfg.ping_pong) begin
                  a[ADDR_W-1] = bank_state;
               end
               exp_q.push_back(model_mem[a]);
            end
         end
      end
   endtask

   task automatic start_run(input int r);
      int b;
      b = r * FIELD_CNT;
      @(posedge clk);
      #1;
      xfer_cfg.ext_addr  = pat_mem[b];
      xfer_cfg.length    = pat_mem[b+1][LEN_W-1:0];
      xfer_cfg.enabled   = pat_mem[b+2][0];
      xfer_cfg.ping_pong = pat_mem[b+3][0];
      agen_cfg.start     = pat_mem[b+4][ADDR_W-1:0];
      agen_cfg.incr      = pat_mem[b+5][ADDR_W-1:0];
      agen_cfg.shift     = pat_mem[b+6][ADDR_W-1:0];
      agen_cfg.incr2     = pat_mem[b+7][ADDR_W-1:0];
      agen_cfg.per       = pat_mem[b+8][PERIOD_W-1:0];
      agen_cfg.duty      = pat_mem[b+9][PERIOD_W-1:0];
      agen_cfg.iter      = pat_mem[b+10][ADDR_W-1:0];
      agen_cfg.iter2     = pat_mem[b+11][ADDR_W-1:0];
      agen_cfg.delay     = pat_mem[b+12][DELAY_W-1:0];
      key                = pat_mem[b+13];
      stall              = pat_mem[b+14][0];
      check_data         = pat_mem[b+15][0];
      // read bank is the new state, fill bank its inverse
      bank_state = xfer_cfg.ping_pong ? ~bank_state : 1'b0;
      build_expected();
      exp_req.addr = xfer_cfg.ext_addr;
      exp_req.len  = xfer_cfg.length;
      exp_beats    = xfer_cfg.enabled ? int'(xfer_cfg.length) : 0;
      out_idx      = 0;
      beat_cnt     = 0;
      run          = 1'b1;
      @(posedge clk);
      #1;
      run         = 1'b0;
      first_cycle = 1'b1;
      in_run      = 1'b1;
   endtask

   // buffer content after the burst holds the words the responder returned
   task automatic store_burst();
      logic [ADDR_W-1:0] a;
      for (int k = 0; k < exp_beats; k++) begin
         a = k;
         if (xfer_cfg.ping_pong) begin
            a[ADDR_W-1] = ~bank_state;
         end
         model_mem[a] = (xfer_cfg.ext_addr + 4 * k) ^ key;
      end
   endtask

   // all DUT outputs sampled at the falling edge
   always @(negedge clk) begin
      if (in_run) begin
         if (first_cycle) begin
            check_value($sformatf("run%0d done low", run_idx), 1'b0, done);
            check_value($sformatf("run%0d dbus_valid", run_idx), xfer_cfg.enabled, dbus_valid);
            first_cycle = 1'b0;
         end
         if (dbus_valid) begin
            check_value($sformatf("run%0d dbus_req", run_idx), exp_req, dbus_req);
            if (dbus_ready) begin
               beat_cnt++;
            end
         end
         if (out_valid) begin
            if (out_idx >= exp_q.size()) begin
               report_failure($sformatf("extra output word %0h", out_data));
            end else if (check_data) begin
               check_value($sformatf("run%0d out[%0d]", run_idx, out_idx),
                           exp_q[out_idx], out_data);
            end
            out_idx++;
         end
         if (done) begin
            check_value($sformatf("run%0d beats", run_idx), exp_beats, beat_cnt);
            check_value($sformatf("run%0d out count", run_idx), exp_q.size(), out_idx);
            in_run       = 1'b0;
            run_finished = 1'b1;
         end
      end else if (dbus_valid || out_valid) begin
         report_failure("databus or output strobe active outside a run");
      end
   end

   // limit grows with the delay, stream and burst length of every run
   initial begin
      #1;
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: the runs did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
   end

   initial begin
      rst          = 1'b1;
      run          = 1'b0;
      xfer_cfg     = '0;
      agen_cfg     = '0;
      stall        = 1'b0;
      key          = '0;
      bank_state   = 1'b0;
      in_run       = 1'b0;
      first_cycle  = 1'b0;
      run_finished = 1'b0;
      check_data   = 1'b0;
      exp_req      = '0;
      err_cnt      = 0;
      check_cnt    = 0;
      cycle_cnt    = 0;
      run_idx      = 0;
      exp_beats    = 0;
      $readmemh("bench/vread_patterns.txt", pat_mem);
      cycle_limit = 20;
      for (int r = 0; r < RUN_CNT; r++) begin
         cycle_limit += pat_mem[r*FIELD_CNT+12] + 4 * pat_mem[r*FIELD_CNT+1];
         cycle_limit += pat_mem[r*FIELD_CNT+11] * pat_mem[r*FIELD_CNT+10]
                        * pat_mem[r*FIELD_CNT+8];
      end

      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_value("reset done", 1'b1, done);
      check_value("reset dbus_valid", 1'b0, dbus_valid);
      check_value("reset out_valid", 1'b0, out_valid);

      if ($isunknown(pat_mem[RUN_CNT*FIELD_CNT-1])) begin
         report_failure("pattern file holds fewer runs than expected");
      end else begin
         for (run_idx = 0; run_idx < RUN_CNT; run_idx++) begin
            start_run(run_idx);
            wait (run_finished);
            run_finished = 1'b0;
            store_burst();
         end
      end

      $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/databus_responder.sv
`timescale 1ns/1ps
`default_nettype none

module databus_responder (
   input  wire                                   clk,
   input  wire                                   rst,
   input  wire                                   stall_i,
   input  wire [31:0]                            key_i,
   input  wire                                   valid_i,
   input  wire vread_bus_pkg::dbus_req_t         req_i,
   output logic                                  ready_o,
   output logic [vread_bus_pkg::AXI_DATA_W-1:0]  rdata_o,
   output logic                                  last_o
);

   import vread_bus_pkg::*;

   logic [LEN_W-1:0] beat_cnt_q;
   logic [15:0]      lfsr_q;

   // fibonacci form with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   initial begin
      ready_o = 1'b0;
      lfsr_q  = 16'd65;
   end

   // ready moves 1 ns after the edge and takes one lfsr bit per cycle with stalls
   always begin
      @(posedge clk);
      #1;
      if (stall_i) begin
         lfsr_q  = lfsr_step(lfsr_q);
         ready_o = lfsr_q[0];
      end else begin
         ready_o = 1'b1;
      end
   end

   // word index inside the current burst
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         beat_cnt_q <= '0;
      end else if (valid_i && ready_o) begin
         if (last_o) begin
            beat_cnt_q <= '0;
         end else begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
      end
   end

   // memory content is the byte address scrambled by the key
   assign rdata_o = (req_i.addr + {beat_cnt_q, 2'b00}) ^ key_i;
   assign last_o  = valid_i && (beat_cnt_q == req_i.len - 1'b1);

endmodule

`default_nettype wire

//--- hw/vread_top.sv
`timescale 1ns/1ps
`default_nettype none

module vread_top (
   input  wire                                   clk,
   input  wire                                   rst,
   input  wire                                   run_i,
   input  wire vread_cfg_pkg::xfer_cfg_t         xfer_cfg_i,
   input  wire vread_cfg_pkg::agen_cfg_t         agen_cfg_i,
   output logic                                  done_o,

   output logic                                  dbus_valid_o,
   output vread_bus_pkg::dbus_req_t              dbus_req_o,
   input  wire                                   dbus_ready_i,
   input  wire [vread_bus_pkg::AXI_DATA_W-1:0]   dbus_rdata_i,
   input  wire                                   dbus_last_i,

   output logic                                  out_valid_o,
   output logic [vread_cfg_pkg::DATA_W-1:0]      out_data_o
);

   import vread_cfg_pkg::*;
   import vread_bus_pkg::*;

   // buffer ports between unit and memory
   buf_wr_t           buf_wr;
   logic              rd_en;
   logic [ADDR_W-1:0] rd_addr;
   logic [DATA_W-1:0] rd_data;

   vread_unit u_unit (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .xfer_cfg_i   (xfer_cfg_i),
      .agen_cfg_i   (agen_cfg_i),
      .done_o       (done_o),
      .dbus_valid_o (dbus_valid_o),
      .dbus_req_o   (dbus_req_o),
      .dbus_ready_i (dbus_ready_i),
      .dbus_rdata_i (dbus_rdata_i),
      .dbus_last_i  (dbus_last_i),
      .out_valid_o  (out_valid_o),
      .out_data_o   (out_data_o),
      .buf_wr_o     (buf_wr),
      .rd_en_o      (rd_en),
      .rd_addr_o    (rd_addr),
      .rd_data_i    (rd_data)
   );

   dual_port_buffer u_buf (
      .clk       (clk),
      .wr_i      (buf_wr),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

endmodule

`default_nettype wire

//--- hw/vread_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vread_unit (
   input  wire                                   clk,
   input  wire                                   rst,
   input  wire                                   run_i,
   input  wire vread_cfg_pkg::xfer_cfg_t         xfer_cfg_i,
   input  wire vread_cfg_pkg::agen_cfg_t         agen_cfg_i,
   output logic                                  done_o,

   output logic                                  dbus_valid_o,
   output vread_bus_pkg::dbus_req_t              dbus_req_o,
   input  wire                                   dbus_ready_i,
   input  wire [vread_bus_pkg::AXI_DATA_W-1:0]   dbus_rdata_i,
   input  wire                                   dbus_last_i,

   output logic                                  out_valid_o,
   output logic [vread_cfg_pkg::DATA_W-1:0]      out_data_o,

   output vread_cfg_pkg::buf_wr_t                buf_wr_o,
   output logic                                  rd_en_o,
   output logic [vread_cfg_pkg::ADDR_W-1:0]      rd_addr_o,
   input  wire [vread_cfg_pkg::DATA_W-1:0]       rd_data_i
);

   import vread_cfg_pkg::*;
   import vread_bus_pkg::*;

   logic              pp_state_q;
   logic              pp_on_q;
   logic              xfer_done_q;
   logic              stream_done_q;
   logic              out_valid_q;
   logic              xfer_start;
   logic              xfer_done;
   logic              gen_valid;
   logic [ADDR_W-1:0] gen_addr;
   logic              gen_done;

   assign xfer_start = run_i & xfer_cfg_i.enabled;

   // bank state flips per run with ping-pong, else parks at zero
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state_q <= 1'b0;
         pp_on_q    <= 1'b0;
      end else if (run_i) begin
         pp_state_q <= xfer_cfg_i.ping_pong ? ~pp_state_q : 1'b0;
         pp_on_q    <= xfer_cfg_i.ping_pong;
      end
   end

   // a disabled transfer counts as finished
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         xfer_done_q   <= 1'b1;
         stream_done_q <= 1'b1;
      end else if (run_i) begin
         xfer_done_q   <= ~xfer_cfg_i.enabled;
         stream_done_q <= 1'b0;
      end else begin
         if (xfer_done) begin
            xfer_done_q <= 1'b1;
         end
         if (gen_done) begin
            stream_done_q <= 1'b1;
         end
      end
   end

   assign done_o = xfer_done_q & stream_done_q;

   // fills the bank opposite to the one being read
   burst_reader u_reader (
      .clk          (clk),
      .rst          (rst),
      .start_i      (xfer_start),
      .xfer_cfg_i   (xfer_cfg_i),
      .fill_bank_i  (~pp_state_q),
      .dbus_valid_o (dbus_valid_o),
      .dbus_req_o   (dbus_req_o),
      .dbus_ready_i (dbus_ready_i),
      .dbus_rdata_i (dbus_rdata_i),
      .dbus_last_i  (dbus_last_i),
      .buf_wr_o     (buf_wr_o),
      .done_o       (xfer_done)
   );

   pattern_addr_gen u_agen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .cfg_i   (agen_cfg_i),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  (gen_done)
   );

   // read side uses the bank given by the state
   assign rd_en_o   = gen_valid;
   assign rd_addr_o = pp_on_q ? {pp_state_q, gen_addr[ADDR_W-2:0]} : gen_addr;

   // strobe follows the registered buffer read
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= gen_valid;
      end
   end

   assign out_valid_o = out_valid_q;
   assign out_data_o  = rd_data_i;

endmodule

`default_nettype wire

//--- hw/dual_port_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_buffer (
   input  wire                                clk,
   input  wire vread_cfg_pkg::buf_wr_t        wr_i,
   input  wire                                rd_en_i,
   input  wire [vread_cfg_pkg::ADDR_W-1:0]    rd_addr_i,
   output logic [vread_cfg_pkg::DATA_W-1:0]   rd_data_o
);

   import vread_cfg_pkg::*;

   // both banks live in one array split by the top address bit
   logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

   // write port
   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // read port word valid the cycle after the strobe
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

//--- hw/pattern_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_addr_gen (
   input  wire                                clk,
   input  wire                                rst,
   input  wire                                run_i,
   input  wire vread_cfg_pkg::agen_cfg_t      cfg_i,
   output logic                               valid_o,
   output logic [vread_cfg_pkg::ADDR_W-1:0]   addr_o,
   output logic                               done_o
);

   import vread_cfg_pkg::*;

   agen_state_e         state_q;
   agen_cfg_t           cfg_q;
   agen_cfg_t           cur_cfg;
   logic [DELAY_W-1:0]  delay_cnt_q;
   logic [PERIOD_W-1:0] per_cnt_q;
   logic [ADDR_W-1:0]   iter_cnt_q;
   logic [ADDR_W-1:0]   iter2_cnt_q;
   logic [ADDR_W-1:0]   base_i_q;
   logic [ADDR_W-1:0]   base_j_q;
   logic [ADDR_W-1:0]   addr_q;
   logic                done_q;
   logic                start_now;
   logic                empty;
   logic                last_p;
   logic                last_i;
   logic                last_j;
   logic [ADDR_W-1:0]   next_inner;
   logic [ADDR_W-1:0]   next_outer;

   always_ff @(posedge clk) begin
      if (run_i) begin
         cfg_q <= cfg_i;
      end
   end

   // on the run cycle itself the live config is the valid one
   assign cur_cfg = run_i ? cfg_i : cfg_q;
   assign empty   = (cur_cfg.iter == '0) || (cur_cfg.iter2 == '0) || (cur_cfg.per == '0);

   // zero delay starts straight away, otherwise after delay cycles in DELAY
   assign start_now = (run_i && cfg_i.delay == '0) ||
                      (!run_i && state_q == DELAY && delay_cnt_q == 1);

   assign last_p = per_cnt_q == cfg_q.per - 1'b1;
   assign last_i = iter_cnt_q == cfg_q.iter - 1'b1;
   assign last_j = iter2_cnt_q == cfg_q.iter2 - 1'b1;

   assign next_inner = base_i_q + cfg_q.shift;
   assign next_outer = base_j_q + cfg_q.incr2;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q     <= IDLE;
         delay_cnt_q <= '0;
         per_cnt_q   <= '0;
         iter_cnt_q  <= '0;
         iter2_cnt_q <= '0;
         base_i_q    <= '0;
         base_j_q    <= '0;
         addr_q      <= '0;
         done_q      <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (start_now) begin
            per_cnt_q   <= '0;
            iter_cnt_q  <= '0;
            iter2_cnt_q <= '0;
            base_i_q    <= cur_cfg.start;
            base_j_q    <= cur_cfg.start;
            addr_q      <= cur_cfg.start;
            if (empty) begin
               state_q <= IDLE;
               done_q  <= 1'b1;
            end else begin
               state_q <= RUN;
            end
         end else if (run_i) begin
            state_q     <= DELAY;
            delay_cnt_q <= cfg_i.delay;
         end else begin
            case (state_q)
               DELAY: delay_cnt_q <= delay_cnt_q - 1'b1;
               RUN: begin
                  if (!last_p) begin
                     per_cnt_q <= per_cnt_q + 1'b1;
                     addr_q    <= addr_q + cfg_q.incr;
                  end else begin
                     per_cnt_q <= '0;
                     if (!last_i) begin
                        // next period of the inner loop
                        iter_cnt_q <= iter_cnt_q + 1'b1;
                        base_i_q   <= next_inner;
                        addr_q     <= next_inner;
                     end else begin
                        iter_cnt_q <= '0;
                        if (!last_j) begin
                           iter2_cnt_q <= iter2_cnt_q + 1'b1;
                           base_j_q    <= next_outer;
                           base_i_q    <= next_outer;
                           addr_q      <= next_outer;
                        end else begin
                           state_q <= IDLE;
                           done_q  <= 1'b1;
                        end
                     end
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // duty cycle gate on the period counter
   assign valid_o = (state_q == RUN) && (per_cnt_q < cfg_q.duty);
   assign addr_o  = addr_q;
   assign done_o  = done_q;

endmodule

`default_nettype wire

//--- hw/burst_reader.sv
`timescale 1ns/1ps
`default_nettype none

module burst_reader (
   input  wire                                   clk,
   input  wire                                   rst,
   input  wire                                   start_i,
   input  wire vread_cfg_pkg::xfer_cfg_t         xfer_cfg_i,
   input  wire                                   fill_bank_i,

   output logic                                  dbus_valid_o,
   output vread_bus_pkg::dbus_req_t              dbus_req_o,
   input  wire                                   dbus_ready_i,
   input  wire [vread_bus_pkg::AXI_DATA_W-1:0]   dbus_rdata_i,
   input  wire                                   dbus_last_i,

   output vread_cfg_pkg::buf_wr_t                buf_wr_o,
   output logic                                  done_o
);

   import vread_cfg_pkg::*;
   import vread_bus_pkg::*;

   logic              valid_q;
   dbus_req_t         req_q;
   logic              pp_q;
   logic [ADDR_W-1:0] fill_addr_q;
   logic              beat;
   logic [ADDR_W-1:0] wr_addr;

   // request is captured at start and held for the whole burst
   always_ff @(posedge clk) begin
      if (start_i) begin
         req_q.addr <= xfer_cfg_i.ext_addr;
         req_q.len  <= xfer_cfg_i.length;
         pp_q       <= xfer_cfg_i.ping_pong;
      end
   end

   // valid stays up until the last beat is taken
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q     <= 1'b0;
         fill_addr_q <= '0;
      end else if (start_i) begin
         valid_q     <= 1'b1;
         fill_addr_q <= '0;
      end else if (beat) begin
         fill_addr_q <= fill_addr_q + 1'b1;
         if (dbus_last_i) begin
            valid_q <= 1'b0;
         end
      end
   end

   // one word per accepted beat
   assign beat = valid_q & dbus_ready_i;

   // bank bit of the fill address swapped in for ping-pong
   always_comb begin
      wr_addr = fill_addr_q;
      if (pp_q) begin
         wr_addr[ADDR_W-1] = fill_bank_i;
      end
   end

   assign dbus_valid_o = valid_q;
   assign dbus_req_o   = req_q;

   assign buf_wr_o.en   = beat;
   assign buf_wr_o.addr = wr_addr;
   assign buf_wr_o.data = dbus_rdata_i;

   // pulse in the cycle the last word is accepted
   assign done_o = beat & dbus_last_i;

endmodule

`default_nettype wire

//--- hw/vread_cfg_pkg.sv
`default_nettype none

package vread_cfg_pkg;

   import vread_bus_pkg::*;

   // top bit of the buffer word address is the bank when ping-pong is on
   localparam int ADDR_W = 10;
   localparam int DATA_W = 32;

   // generator counter widths
   localparam int PERIOD_W = 8;
   localparam int DELAY_W  = 8;

   // two-level output pattern
   typedef struct packed {
      logic [ADDR_W-1:0]   start;
      logic [ADDR_W-1:0]   incr;
      logic [ADDR_W-1:0]   shift;
      logic [ADDR_W-1:0]   incr2;
      logic [PERIOD_W-1:0] per;
      logic [PERIOD_W-1:0] duty;
      logic [ADDR_W-1:0]   iter;
      logic [ADDR_W-1:0]   iter2;
      logic [DELAY_W-1:0]  delay;
   } agen_cfg_t;

   // burst from external memory into the buffer
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] ext_addr;
      logic [LEN_W-1:0]      length;
      logic                  enabled;
      logic                  ping_pong;
   } xfer_cfg_t;

   // one buffer write
   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } buf_wr_t;

   typedef enum logic [1:0] {
      IDLE,
      DELAY,
      RUN
   } agen_state_e;

endpackage

`default_nettype wire

//--- hw/vread_bus_pkg.sv
`default_nettype none

package vread_bus_pkg;

   // external memory side of the read unit
   // byte address and bus word widths
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;

   // burst length field counted in bus words
   localparam int LEN_W = 16;

   // request held on the databus for a whole burst
   // addr is a byte address, len the number of words
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [LEN_W-1:0]      len;
   } dbus_req_t;

endpackage

`default_nettype wire
